//--- hw/gate_apd_pkg.sv
`default_nettype none

package gate_apd_pkg;

    //////////////////////////////
    // field widths

    // duty cycle of the gate, in clk240 cycles
    localparam int duty_w = 4;
    // coarse tune delay select, only 0 to 7 reach the shift line
    localparam int tune_w = 4;
    // fine-delay window length, in clk240 cycles
    localparam int res_w = 14;

    // master, slave 1, slave 2
    localparam int num_chan = 3;

    //////////////////////////////
    // configuration words

    // gate generator settings
    typedef struct packed {
        logic [duty_w-1:0] duty;
        logic [tune_w-1:0] tune;
    } gate_cfg_t;

    // one fine-delay channel
    typedef struct packed {
        // window length in cycles
        logic [res_w-1:0] resolution;
        // step direction, 1 moves the tap up
        logic             increase;
    } chan_cfg_t;

    // full parameter word, loaded on params_load_i
    // chan[0] is the master channel
    typedef struct packed {
        gate_cfg_t                    gate;
        chan_cfg_t [num_chan-1:0]     chan;
    } gate_apd_cfg_t;

    //////////////////////////////
    // delay-line step control

    typedef struct packed {
        // one-cycle step strobe
        logic ce;
        // direction for the strobe
        logic inc;
        // voltage/temperature compensation hold, high when idle
        logic en_vtc;
    } dly_step_t;

endpackage

`default_nettype wire

//--- hw/gate_pulse_gen.sv
`default_nettype none

module gate_pulse_gen
    import gate_apd_pkg::*;
#(
    // gate period in clk240 cycles, 2 to 31
    parameter int gate_period = 3
) (
    input  wire        clk240,
    input  wire        ttl_rst240_o,
    input  logic       pps_i,
    input  logic       params_load_i,
    input  gate_cfg_t  gate_cfg_i,
    output logic       gate_o,
    output logic       gate_rep_o
);

    // taps 0..7 of the tune shift line
    localparam int line_depth = 8;
    localparam int tap_w      = $clog2(line_depth);
    localparam int cnt_w      = $clog2(gate_period);

    // last count value before wrapping
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(gate_period - 1);
    // largest tune the line can serve
    localparam logic [tune_w-1:0] tune_max = tune_w'(line_depth - 1);

    logic [duty_w-1:0]     duty_q;
    logic [tune_w-1:0]     tune_q;
    logic                  pps_q;
    logic                  armed_q;
    logic [cnt_w-1:0]      cnt_q;
    logic                  pulse_q;
    logic [line_depth-1:0] line_q;
    logic [tap_w-1:0]      tap;

    //////////////////////////////
    // parameter copy

    // new duty and tune apply from the cycle after the load strobe
    always_ff @(posedge clk240) begin
        if (ttl_rst240_o) begin
            duty_q <= '0;
            tune_q <= '0;
        end else if (params_load_i) begin
            duty_q <= gate_cfg_i.duty;
            tune_q <= gate_cfg_i.tune;
        end
    end

    //////////////////////////////
    // pps arming

    // rising edge of pps arms once, cleared only by reset
    always_ff @(posedge clk240) begin
        if (ttl_rst240_o) begin
            pps_q   <= 1'b0;
            armed_q <= 1'b0;
        end else begin
            pps_q <= pps_i;
            if (pps_i && !pps_q) begin
                armed_q <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // gate pulse and tune line

    always_ff @(posedge clk240) begin
        if (ttl_rst240_o) begin
            cnt_q   <= '0;
            pulse_q <= 1'b0;
            line_q  <= '0;
        end else if (!armed_q) begin
            // idle until pps, everything held clear
            cnt_q   <= '0;
            pulse_q <= 1'b0;
            line_q  <= '0;
        end else begin
            // high for the first duty counts of each period
            pulse_q <= (int'(cnt_q) < int'(duty_q));
            // wrap at the end of the period
            if (cnt_q == cnt_last) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + cnt_w'(1);
            end
            // line_q[i] holds the pulse from i+1 cycles back
            line_q <= {line_q[line_depth-2:0], pulse_q};
        end
    end

    // tune above 7 clamps to the last tap
    always_comb begin
        if (tune_q > tune_max) begin
            tap = tap_w'(line_depth - 1);
        end else begin
            tap = tap_w'(tune_q);
        end
    end

    // delayed gate, tune+1 cycles behind the repeat
    assign gate_o     = line_q[tap];
    assign gate_rep_o = pulse_q;

endmodule

`default_nettype wire

//--- hw/fine_step_ctrl.sv
`default_nettype none

module fine_step_ctrl
    import gate_apd_pkg::*;
#(
    // cycles between two step strobes, 3 or more
    parameter int step_period = 17,
    // strobe position inside the period, below step_period
    parameter int step_phase  = 9
) (
    input  wire        clk240,
    input  wire        ttl_rst240_o,
    input  logic       params_load_i,
    input  chan_cfg_t  chan_cfg_i,
    input  logic       step_en_i,
    output dly_step_t  dly_step_o
);

    // one extra bit so resolution+1 fits
    localparam int win_w = res_w + 1;
    // wide enough to hold step_period itself
    localparam int ph_w  = $clog2(step_period + 1);

    localparam logic [ph_w-1:0] ph_last   = ph_w'(step_period - 1);
    // phase value where ce is high
    localparam logic [ph_w-1:0] ph_strobe = ph_w'(step_phase + 1);

    logic [res_w-1:0] res_q;
    logic             increase_q;
    logic [win_w-1:0] win_cnt_q;
    logic [win_w-1:0] win_end;
    logic             win_open;
    logic             active_q;
    logic [ph_w-1:0]  phase_q;
    logic [ph_w-1:0]  phase_d;
    logic             ce_q;
    logic             inc_q;

    //////////////////////////////
    // channel parameters

    always_ff @(posedge clk240) begin
        if (ttl_rst240_o) begin
            res_q      <= '0;
            increase_q <= 1'b0;
        end else if (params_load_i) begin
            res_q      <= chan_cfg_i.resolution;
            increase_q <= chan_cfg_i.increase;
        end
    end

    //////////////////////////////
    // step window

    // saturation point, also the idle value
    assign win_end = {1'b0, res_q} + win_w'(1);

    // counter in 1..resolution opens the window one cycle later
    assign win_open = (win_cnt_q != '0) && (win_cnt_q <= {1'b0, res_q});

    always_ff @(posedge clk240) begin
        if (ttl_rst240_o) begin
            win_cnt_q <= win_end;
        end else if (!step_en_i) begin
            // enable low rearms the window
            win_cnt_q <= '0;
        end else if (win_cnt_q < win_end) begin
            win_cnt_q <= win_cnt_q + win_w'(1);
        end
    end

    always_ff @(posedge clk240) begin
        if (ttl_rst240_o) begin
            active_q <= 1'b0;
        end else begin
            active_q <= win_open;
        end
    end

    //////////////////////////////
    // step strobe timing

    // phase of the next cycle, restarts at 0 on the first active cycle
    always_comb begin
        if (!active_q) begin
            phase_d = '0;
        end else if (phase_q == ph_last) begin
            phase_d = '0;
        end else begin
            phase_d = phase_q + ph_w'(1);
        end
    end

    always_ff @(posedge clk240) begin
        if (ttl_rst240_o) begin
            phase_q <= '0;
            ce_q    <= 1'b0;
            inc_q   <= 1'b0;
        end else begin
            phase_q <= phase_d;
            // strobe lands in the next cycle, only inside the window
            ce_q    <= win_open && (phase_d == ph_strobe);
            // direction sampled together with each strobe
            if (win_open && (phase_d == ph_strobe)) begin
                inc_q <= increase_q;
            end
        end
    end

    // compensation hold released only while the window is open
    always_comb begin
        dly_step_o.ce     = ce_q;
        dly_step_o.inc    = inc_q;
        dly_step_o.en_vtc = !active_q;
    end

endmodule

`default_nettype wire

//--- hw/gate_apd_top.sv
`default_nettype none

module gate_apd_top
    import gate_apd_pkg::*;
#(
    // gate period, cycles
    parameter int gate_period = 3,
    // fine-step strobe period and position
    parameter int step_period = 17,
    parameter int step_phase  = 9
) (
    input  wire                        clk240,
    input  wire                        ttl_rst240_o,
    input  logic                       pps_i,
    input  logic                       params_load_i,
    input  gate_apd_cfg_t              cfg_i,
    // one enable level per fine-delay channel
    input  logic [num_chan-1:0]        step_en_i,
    output logic                       gate_o,
    output logic                       gate_rep_o,
    // step control toward the delay lines
    output dly_step_t [num_chan-1:0]   dly_step_o
);

    //////////////////////////////
    // gate generation

    // pps arming, duty pulse and coarse tune delay
    gate_pulse_gen #(
        .gate_period   (gate_period)
    ) u_gate (
        .clk240        (clk240),
        .ttl_rst240_o  (ttl_rst240_o),
        .pps_i         (pps_i),
        .params_load_i (params_load_i),
        .gate_cfg_i    (cfg_i.gate),
        .gate_o        (gate_o),
        .gate_rep_o    (gate_rep_o)
    );

    //////////////////////////////
    // fine-delay step control

    // channel 0 master, 1 and 2 the cascaded slaves
    // all share the load strobe, each copies its own field
    for (genvar n = 0; n < num_chan; n++) begin : g_chan
        fine_step_ctrl #(
            .step_period   (step_period),
            .step_phase    (step_phase)
        ) u_step (
            .clk240        (clk240),
            .ttl_rst240_o  (ttl_rst240_o),
            .params_load_i (params_load_i),
            .chan_cfg_i    (cfg_i.chan[n]),
            .step_en_i     (step_en_i[n]),
            .dly_step_o    (dly_step_o[n])
        );
    end

endmodule

`default_nettype wire

//--- verif/gate_apd_ref.svh
`ifndef gate_apd_ref_svh
`define gate_apd_ref_svh

`default_nettype none

//////////////////////////////
// gate generator

// gate_rep_o in the cycle after armed cycle k
// high for the first duty cycles of every period
// duty of period or more keeps it high
function automatic bit expected_gate_level(input int k, input int duty, input int period);
    return (k % period) < duty;
endfunction

//////////////////////////////
// fine-delay step windows

// ce in active cycle m of a window
// one strobe per period, at phase+1
function automatic bit strobe_due(input int m, input int period, input int phase);
    return (m % period) == (phase + 1);
endfunction

// strobes inside a window of res active cycles
function automatic int steps_in_window(input int res, input int period, input int phase);
    int first;
    int count;
    // first strobe position inside the window
    first = phase + 1;
    if ((first >= period) || (res <= first)) begin
        // strobe slot never reached
        count = 0;
    end else begin
        // slots at first, first+period, ... below res
        count = (res - first - 1) / period + 1;
    end
    return count;
endfunction

`default_nettype wire

`endif

//--- verif/gate_apd_tb.sv
`include "gate_apd_ref.svh"
`default_nettype none

module gate_apd_tb
    import gate_apd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int gate_period = 3;
    localparam int step_period = 17;
    localparam int step_phase  = 9;
    localparam int num_cfg     = 4;
    // 4 configs, two windows of up to 1000 cycles plus one cut window each
    localparam int max_cycles  = 20000;
    localparam int unsigned rand_seed = 32'h8b36_a7f9;

    logic                     clk240;
    logic                     ttl_rst240_o;
    logic                     pps_i;
    logic                     params_load_i;
    gate_apd_cfg_t            cfg_i;
    logic [num_chan-1:0]      step_en_i;
    logic                     gate_o;
    logic                     gate_rep_o;
    dly_step_t [num_chan-1:0] dly_step_o;

    // model state, one entry per cycle of the dut
    bit model_valid;
    int duty_m;
    int tune_m;
    bit pps_m;
    bit armed_m;
    int arm_idx;
    // rep_hist[i] is gate_rep_o from i cycles back
    bit rep_hist[0:8];
    int res_m[num_chan];
    bit inc_m[num_chan];
    // run of high step_en cycles ending 1 and 2 cycles back
    int run1[num_chan];
    int run2[num_chan];
    // dut window seen open in the previous cycle
    bit act_prev[num_chan];
    int win_len[num_chan];
    int ce_cnt[num_chan];
    int full_win[num_chan];

    gate_apd_top #(
        .gate_period   (gate_period),
        .step_period   (step_period),
        .step_phase    (step_phase)
    ) dut0 (
        .clk240        (clk240),
        .ttl_rst240_o  (ttl_rst240_o),
        .pps_i         (pps_i),
        .params_load_i (params_load_i),
        .cfg_i         (cfg_i),
        .step_en_i     (step_en_i),
        .gate_o        (gate_o),
        .gate_rep_o    (gate_rep_o),
        .dly_step_o    (dly_step_o)
    );

    initial begin : clock_gen
        clk240 = 1'b0;
        forever #2 clk240 = ~clk240;
    end

    task automatic stop_on_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    // n rising edges, then 1 ns into the cycle
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk240);
            #1;
        end
    endtask

    // pick 0 forces duty 0, pick 1 forces full duty
    task automatic load_config(input int pick);
        gate_apd_cfg_t cfg;
        cfg.gate.duty = duty_w'($urandom_range(15, 0));
        if (pick == 0) begin
            cfg.gate.duty = '0;
        end else if (pick == 1) begin
            cfg.gate.duty = duty_w'(15);
        end
        cfg.gate.tune = tune_w'($urandom_range(7, 0));
        for (int ch = 0; ch < num_chan; ch++) begin
            cfg.chan[ch].resolution = res_w'($urandom_range(1000, 1));
            cfg.chan[ch].increase   = 1'($urandom_range(1, 0));
        end
        cfg_i         = cfg;
        params_load_i = 1'b1;
        wait_cycles(1);
        params_load_i = 1'b0;
    endtask

    // hold step_en until every channel closed one full window
    task automatic run_full_window();
        int  done_before[num_chan];
        bit  waiting;
        done_before = full_win;
        step_en_i   = '1;
        waiting     = 1'b1;
        while (waiting) begin
            wait_cycles(1);
            waiting = 1'b0;
            for (int ch = 0; ch < num_chan; ch++) begin
                if (full_win[ch] == done_before[ch]) begin
                    waiting = 1'b1;
                end
            end
        end
    endtask

    // lower step_en while every window is still open
    // hold must return within 2 cycles
    task automatic drop_window();
        int cut;
        int res_min;
        res_min = res_m[0];
        for (int ch = 1; ch < num_chan; ch++) begin
            if (res_m[ch] < res_min) begin
                res_min = res_m[ch];
            end
        end
        // shortest window still running at the drop
        cut       = int'($urandom_range(res_min, 2));
        step_en_i = '1;
        wait_cycles(cut);
        step_en_i = '0;
        wait_cycles(2);
        for (int ch = 0; ch < num_chan; ch++) begin
            assert (dly_step_o[ch].en_vtc && !dly_step_o[ch].ce)
            else stop_on_mismatch($sformatf("ch%0d still stepping 2 cycles after drop", ch));
        end
        wait_cycles(2);
    endtask

    //////////////////////////////
    // comparison process

    // sampled at the falling edge, between drive and capture
    always @(negedge clk240) begin : compare
        bit act;
        bit exp_ce;
        if (model_valid) begin
            assert (gate_rep_o === rep_hist[0])
            else stop_on_mismatch($sformatf("gate_rep_o %b, expected %b", gate_rep_o,
                                            rep_hist[0]));
            // tune+1 cycles behind the repeat
            assert (gate_o === rep_hist[tune_m + 1])
            else stop_on_mismatch($sformatf("gate_o %b, expected %b at tune %0d", gate_o,
                                            rep_hist[tune_m + 1], tune_m));
            for (int ch = 0; ch < num_chan; ch++) begin
                // active when the run two cycles back is 1..resolution
                act    = (run2[ch] >= 1) && (run2[ch] <= res_m[ch]);
                exp_ce = act && strobe_due(run2[ch] - 1, step_period, step_phase);
                assert (dly_step_o[ch].en_vtc === !act)
                else stop_on_mismatch($sformatf("ch%0d en_vtc %b, expected %b", ch,
                                                dly_step_o[ch].en_vtc, !act));
                assert (dly_step_o[ch].ce === exp_ce)
                else stop_on_mismatch($sformatf("ch%0d ce %b, expected %b", ch,
                                                dly_step_o[ch].ce, exp_ce));
                if (exp_ce) begin
                    assert (dly_step_o[ch].inc === inc_m[ch])
                    else stop_on_mismatch($sformatf("ch%0d inc %b at strobe, expected %b",
                                                    ch, dly_step_o[ch].inc, inc_m[ch]));
                end
                // window length and strobes as the dut shows them
                if (!dly_step_o[ch].en_vtc) begin
                    win_len[ch]++;
                    if (dly_step_o[ch].ce) begin
                        ce_cnt[ch]++;
                    end
                end else if (act_prev[ch]) begin
                    // closed by saturation, not by a drop
                    if (run2[ch] > res_m[ch]) begin
                        assert ((win_len[ch] == res_m[ch]) && (ce_cnt[ch] ==
                                steps_in_window(res_m[ch], step_period, step_phase)))
                        else stop_on_mismatch($sformatf("ch%0d window %0d cycles %0d steps",
                                                        ch, win_len[ch], ce_cnt[ch]));
                        full_win[ch]++;
                    end
                    win_len[ch] = 0;
                    ce_cnt[ch]  = 0;
                end
                act_prev[ch] = !dly_step_o[ch].en_vtc;
            end
        end
        // advance the model by one cycle
        if (ttl_rst240_o) begin
            duty_m   = 0;
            tune_m   = 0;
            pps_m    = 1'b0;
            armed_m  = 1'b0;
            arm_idx  = 0;
            rep_hist = '{default: 1'b0};
            for (int ch = 0; ch < num_chan; ch++) begin
                res_m[ch]    = 0;
                inc_m[ch]    = 1'b0;
                run1[ch]     = 0;
                run2[ch]     = 0;
                act_prev[ch] = 1'b0;
                win_len[ch]  = 0;
                ce_cnt[ch]   = 0;
            end
            model_valid = 1'b1;
        end else begin
            for (int i = 8; i > 0; i--) begin
                rep_hist[i] = rep_hist[i-1];
            end
            rep_hist[0] = armed_m && expected_gate_level(arm_idx, duty_m, gate_period);
            if (armed_m) begin
                arm_idx++;
            end
            // pps rising edge arms from the next cycle on
            if (pps_i && !pps_m) begin
                armed_m = 1'b1;
            end
            pps_m = pps_i;
            for (int ch = 0; ch < num_chan; ch++) begin
                run2[ch] = run1[ch];
                run1[ch] = step_en_i[ch] ? run1[ch] + 1 : 0;
            end
            // channel loads happen only while step_en is low
            if (params_load_i) begin
                duty_m = int'(cfg_i.gate.duty);
                tune_m = int'(cfg_i.gate.tune);
                for (int ch = 0; ch < num_chan; ch++) begin
                    res_m[ch] = int'(cfg_i.chan[ch].resolution);
                    inc_m[ch] = cfg_i.chan[ch].increase;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk240);
            cycles++;
            if (cycles >= max_cycles) begin
                $display("SIMULATION FAILED");
                $fatal(1, "timeout, tests did not finish within %0d cycles", max_cycles);
            end
        end
    end

    //////////////////////////////
    // stimulus

    initial begin : stimulus
        void'($urandom(rand_seed));
        ttl_rst240_o  = 1'b1;
        pps_i         = 1'b0;
        params_load_i = 1'b0;
        cfg_i         = '0;
        step_en_i     = '0;
        wait_cycles(2);
        ttl_rst240_o = 1'b0;
        // idle with settings loaded, nothing may move before pps
        load_config(2);
        wait_cycles(20);
        pps_i = 1'b1;
        wait_cycles(3);
        pps_i = 1'b0;
        for (int i = 0; i < num_cfg; i++) begin
            // reload while armed
            load_config(i);
            wait_cycles(5);
            run_full_window();
            step_en_i = '0;
            wait_cycles(4);
            drop_window();
            run_full_window();
            step_en_i = '0;
            wait_cycles(4);
        end
        wait_cycles(10);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verif
hw/gate_apd_pkg.sv
hw/gate_pulse_gen.sv
hw/fine_step_ctrl.sv
hw/gate_apd_top.sv
verif/gate_apd_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := gate_apd_tb
RTL_TOP    := gate_apd_top
FILELIST   := verilog.f
RTL_SRCS   := hw/gate_apd_pkg.sv hw/gate_pulse_gen.sv hw/fine_step_ctrl.sv hw/gate_apd_top.sv
TB_SRCS    := verif/gate_apd_tb.sv verif/gate_apd_ref.svh
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary -j 0
OBJ_DIR    := obj_dir
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# design alone, then design with testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a failing run ends in $$fatal, so make sees a nonzero status
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
